/* Makefile */
VERILATOR ?= verilator
TOP       ?= pkt_fifo_async_tb
FLIST     ?= pkt_fifo_async.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/fifo_wr_if.sv */
// write port and commit pointer from ingress into the storage array
`default_nettype none
`timescale 1ns/1ps

interface fifo_wr_if;
   import pkt_fifo_pkg::*;

   // write port, all in clk_in
   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   logic [WORD_W-1:0] wr_word;      // {last, keep, data}

   // just past the last word of the newest complete packet
   logic [PTR_W-1:0]  commit_ptr;

   // read pointer after its crossing into clk_in
   logic [PTR_W-1:0]  rd_ptr_wsync;

   modport ingress (
      output wr_en, wr_addr, wr_word, commit_ptr,
      input  rd_ptr_wsync
   );

   modport mem (
      input  wr_en, wr_addr, wr_word, commit_ptr,
      output rd_ptr_wsync
   );

endinterface

`default_nettype wire

/* design/pkt_egress.sv */
// read side: read pointer, output register stage with valid/ready
// handshake, reset release into clk_out
`default_nettype none
`timescale 1ns/1ps

module pkt_egress (
   input  logic                          clk_out,
   input  logic                          arst_n,
   input  logic [pkt_fifo_pkg::WORD_W-1:0]  rd_word,
   input  logic [pkt_fifo_pkg::PTR_W-1:0]   commit_rsync,
   input  logic                          out_tready,
   output logic [pkt_fifo_pkg::PTR_W-1:0]   rd_ptr,
   output logic                          out_tvalid,
   output logic                          out_tlast,
   output logic [pkt_fifo_pkg::DATA_W-1:0]  out_tdata,
   output logic [pkt_fifo_pkg::KEEP_W-1:0]  out_tkeep
);
   import pkt_fifo_pkg::*;

   logic [1:0] rst_sync_q;
   logic       rst_out_n;
   logic       avail;      // committed words not yet loaded
   logic       load;

   // ------------------------------------------------------------------
   // reset release
   // ------------------------------------------------------------------
   always_ff @(posedge clk_out or negedge arst_n) begin
      if (!arst_n) begin
         rst_sync_q <= '0;
      end else begin
         rst_sync_q <= {rst_sync_q[0], 1'b1};
      end
   end

   assign rst_out_n = rst_sync_q[1];

   // reload in the same cycle the held word is taken
   assign avail = (rd_ptr != commit_rsync);
   assign load  = avail && (!out_tvalid || out_tready);

   always_ff @(posedge clk_out or negedge rst_out_n) begin
      if (!rst_out_n) begin
         rd_ptr     <= '0;
         out_tvalid <= 1'b0;
      end else if (load) begin
         rd_ptr     <= rd_ptr + 1'b1;
         out_tvalid <= 1'b1;
      end else if (out_tready) begin
         out_tvalid <= 1'b0;      // stage drained
      end
   end

   // payload only
   always_ff @(posedge clk_out) begin
      if (load) {out_tlast, out_tkeep, out_tdata} <= rd_word;
   end

endmodule

`default_nettype wire

/* design/pkt_fifo_async.sv */
// packet-aware async FIFO top level: ingress, dual-clock storage,
// egress output stage
`default_nettype none
`timescale 1ns/1ps

module pkt_fifo_async (
   input  logic                         clk_in,
   input  logic                         clk_out,
   input  logic                         arst_n,
   // input stream, clk_in
   input  logic                         in_tvalid,
   input  logic [pkt_fifo_pkg::DATA_W-1:0] in_tdata,
   input  logic [pkt_fifo_pkg::KEEP_W-1:0] in_tkeep,
   input  logic                         in_tlast,
   input  logic [pkt_fifo_pkg::CNT_W-1:0]  flow_ctl_thresh,
   output logic                         flow_ctl,
   output logic [pkt_fifo_pkg::CNT_W-1:0]  drop_count,
   // output stream, clk_out
   output logic                         out_tvalid,
   output logic [pkt_fifo_pkg::DATA_W-1:0] out_tdata,
   output logic [pkt_fifo_pkg::KEEP_W-1:0] out_tkeep,
   output logic                         out_tlast,
   input  logic                         out_tready
);
   import pkt_fifo_pkg::*;

   fifo_wr_if wr_if ();

   logic [PTR_W-1:0]  rd_ptr;
   logic [WORD_W-1:0] rd_word;
   logic [PTR_W-1:0]  commit_rsync;

   pkt_ingress pkt_ingress_inst (
      .clk_in          (clk_in),
      .arst_n          (arst_n),
      .in_tvalid       (in_tvalid),
      .in_tlast        (in_tlast),
      .in_tdata        (in_tdata),
      .in_tkeep        (in_tkeep),
      .flow_ctl_thresh (flow_ctl_thresh),
      .flow_ctl        (flow_ctl),
      .drop_count      (drop_count),
      .wr              (wr_if.ingress)
   );

   pkt_fifo_mem pkt_fifo_mem_inst (
      .clk_in       (clk_in),
      .clk_out      (clk_out),
      .arst_n       (arst_n),
      .rd_ptr       (rd_ptr),
      .rd_word      (rd_word),
      .commit_rsync (commit_rsync),
      .wr           (wr_if.mem)
   );

   pkt_egress pkt_egress_inst (
      .clk_out      (clk_out),
      .arst_n       (arst_n),
      .rd_word      (rd_word),
      .commit_rsync (commit_rsync),
      .out_tready   (out_tready),
      .rd_ptr       (rd_ptr),
      .out_tvalid   (out_tvalid),
      .out_tlast    (out_tlast),
      .out_tdata    (out_tdata),
      .out_tkeep    (out_tkeep)
   );

endmodule

`default_nettype wire

/* design/pkt_fifo_mem.sv */
// dual-clock word storage with gray-coded crossing of the commit
// pointer into clk_out and of the read pointer into clk_in
`default_nettype none
`timescale 1ns/1ps

module pkt_fifo_mem (
   input  logic                         clk_in,
   input  logic                         clk_out,
   input  logic                         arst_n,
   input  logic [pkt_fifo_pkg::PTR_W-1:0]  rd_ptr,
   output logic [pkt_fifo_pkg::WORD_W-1:0] rd_word,
   output logic [pkt_fifo_pkg::PTR_W-1:0]  commit_rsync,
   fifo_wr_if.mem                       wr
);
   import pkt_fifo_pkg::*;

   function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
      logic [PTR_W-1:0] b;
      b[PTR_W-1] = g[PTR_W-1];
      for (int i = PTR_W - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   logic [WORD_W-1:0] mem_q [DEPTH];

   logic [PTR_W-1:0]  commit_gray_q;     // clk_in
   logic [PTR_W-1:0]  commit_sync_q [2]; // clk_out
   logic [PTR_W-1:0]  rd_gray_q;         // clk_out
   logic [PTR_W-1:0]  rd_sync_q [2];     // clk_in

   // ------------------------------------------------------------------
   // storage, written in clk_in, read by address
   // ------------------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (wr.wr_en) mem_q[wr.wr_addr] <= wr.wr_word;
   end

   assign rd_word = mem_q[rd_ptr[ADDR_W-1:0]];

   // ------------------------------------------------------------------
   // commit pointer into clk_out
   // ------------------------------------------------------------------
   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) commit_gray_q <= '0;
      else         commit_gray_q <= bin2gray(wr.commit_ptr);  // no glitch into sync
   end

   always_ff @(posedge clk_out or negedge arst_n) begin
      if (!arst_n) begin
         commit_sync_q[0] <= '0;
         commit_sync_q[1] <= '0;
      end else begin
         commit_sync_q[0] <= commit_gray_q;
         commit_sync_q[1] <= commit_sync_q[0];
      end
   end

   assign commit_rsync = gray2bin(commit_sync_q[1]);

   // ------------------------------------------------------------------
   // read pointer into clk_in
   // ------------------------------------------------------------------
   always_ff @(posedge clk_out or negedge arst_n) begin
      if (!arst_n) rd_gray_q <= '0;
      else         rd_gray_q <= bin2gray(rd_ptr);
   end

   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) begin
         rd_sync_q[0] <= '0;
         rd_sync_q[1] <= '0;
      end else begin
         rd_sync_q[0] <= rd_gray_q;
         rd_sync_q[1] <= rd_sync_q[0];
      end
   end

   assign wr.rd_ptr_wsync = gray2bin(rd_sync_q[1]);

endmodule

`default_nettype wire

/* design/pkt_fifo_pkg.sv */
// stream, word and pointer widths for the packet FIFO
// FIFO depth and drop counter width
`default_nettype none

package pkt_fifo_pkg;

   // ------------------------------------------------------------------
   // stream
   // ------------------------------------------------------------------
   localparam int DATA_W = 32;
   localparam int KEEP_W = DATA_W / 8;    // one enable per byte

   // stored word packs last, keep and data, with last on top
   localparam int WORD_W = DATA_W + KEEP_W + 1;

   // ------------------------------------------------------------------
   // storage and pointers
   // ------------------------------------------------------------------
   localparam int DEPTH  = 64;             // words, power of two
   localparam int ADDR_W = $clog2(DEPTH);

   // one extra bit tells full from empty when the addresses match
   localparam int PTR_W  = ADDR_W + 1;

   // ------------------------------------------------------------------
   // status
   // ------------------------------------------------------------------
   localparam int CNT_W  = 16;             // drop counter, flow threshold

endpackage

`default_nettype wire

/* design/pkt_ingress.sv */
// write side: packet framing, discard on overflow with pointer rewind,
// fill-level flow control and drop counter
`default_nettype none
`timescale 1ns/1ps

module pkt_ingress (
   input  logic                        clk_in,
   input  logic                        arst_n,
   input  logic                        in_tvalid,
   input  logic                        in_tlast,
   input  logic [pkt_fifo_pkg::DATA_W-1:0] in_tdata,
   input  logic [pkt_fifo_pkg::KEEP_W-1:0] in_tkeep,
   input  logic [pkt_fifo_pkg::CNT_W-1:0]  flow_ctl_thresh,
   output logic                        flow_ctl,
   output logic [pkt_fifo_pkg::CNT_W-1:0]  drop_count,
   fifo_wr_if.ingress                  wr
);
   import pkt_fifo_pkg::*;

   logic [1:0]       rst_sync_q;
   logic             rst_in_n;        // arst_n with release in clk_in
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] commit_ptr;
   logic [PTR_W-1:0] used;
   logic             full;
   logic             discarding;
   logic             accept;
   logic             drop_word;

   // ------------------------------------------------------------------
   // reset release
   // ------------------------------------------------------------------
   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) begin
         rst_sync_q <= '0;
      end else begin
         rst_sync_q <= {rst_sync_q[0], 1'b1};
      end
   end

   assign rst_in_n = rst_sync_q[1];

   // ------------------------------------------------------------------
   // fill level and word decision
   // ------------------------------------------------------------------
   assign used      = wr_ptr - wr.rd_ptr_wsync;   // includes open packet
   assign full      = (used == PTR_W'(DEPTH));
   assign accept    = in_tvalid && !discarding && !full;
   assign drop_word = in_tvalid && (discarding || full);

   assign wr.wr_en      = accept;
   assign wr.wr_addr    = wr_ptr[ADDR_W-1:0];
   assign wr.wr_word    = {in_tlast, in_tkeep, in_tdata};
   assign wr.commit_ptr = commit_ptr;

   // ------------------------------------------------------------------
   // pointers, discard state, status
   // ------------------------------------------------------------------
   always_ff @(posedge clk_in or negedge rst_in_n) begin
      if (!rst_in_n) begin
         wr_ptr     <= '0;
         commit_ptr <= '0;
         discarding <= 1'b0;
         drop_count <= '0;
         flow_ctl   <= 1'b0;
      end else begin
         if (drop_word && in_tlast) begin
            // whole packet lost, back to the last boundary
            discarding <= 1'b0;
            wr_ptr     <= commit_ptr;
            drop_count <= drop_count + 1'b1;
         end else begin
            if (drop_word) discarding <= 1'b1;   // first word with no room
            if (accept) wr_ptr <= wr_ptr + 1'b1;
            if (accept && in_tlast) begin
               commit_ptr <= wr_ptr + 1'b1;      // packet now visible
            end
         end
         flow_ctl <= (CNT_W'(used) > flow_ctl_thresh);
      end
   end

endmodule

`default_nettype wire

/* pkt_fifo_async.f */
design/pkt_fifo_pkg.sv
design/fifo_wr_if.sv
design/pkt_ingress.sv
design/pkt_fifo_mem.sv
design/pkt_egress.sv
design/pkt_fifo_async.sv
testbench/tb_clk_gen.sv
testbench/pkt_fifo_async_sva.sv
testbench/pkt_fifo_async_tb.sv

/* testbench/pkt_fifo_async_sva.sv */
// output handshake, reset and drop counter assertions for the top level
`default_nettype none
`timescale 1ns/1ps

module pkt_fifo_async_sva (
   input logic                         clk_in,
   input logic                         clk_out,
   input logic                         arst_n,
   input logic                         out_tvalid,
   input logic                         out_tready,
   input logic                         out_tlast,
   input logic [pkt_fifo_pkg::DATA_W-1:0] out_tdata,
   input logic [pkt_fifo_pkg::KEEP_W-1:0] out_tkeep,
   input logic [pkt_fifo_pkg::CNT_W-1:0]  drop_count
);

   // a stalled word stays put until taken
   hold_while_stalled: assert property (@(posedge clk_out) disable iff (!arst_n)
      out_tvalid && !out_tready |=> out_tvalid && $stable({out_tlast, out_tkeep, out_tdata}))
      else $error("output word dropped or changed while out_tready was low");

   no_valid_in_reset: assert property (@(posedge clk_out) !arst_n |-> !out_tvalid)
      else $error("out_tvalid high during reset");

   drops_only_rise: assert property (@(posedge clk_in) disable iff (!arst_n)
      drop_count >= $past(drop_count))
      else $error("drop_count went down");

endmodule

bind pkt_fifo_async pkt_fifo_async_sva pkt_fifo_async_sva_inst (
   .clk_in     (clk_in),
   .clk_out    (clk_out),
   .arst_n     (arst_n),
   .out_tvalid (out_tvalid),
   .out_tready (out_tready),
   .out_tlast  (out_tlast),
   .out_tdata  (out_tdata),
   .out_tkeep  (out_tkeep),
   .drop_count (drop_count)
);

`default_nettype wire

/* testbench/pkt_fifo_async_tb.sv */
// testbench for the packet FIFO: random packets, expected-word queue,
// output monitor, overflow and flow-control checks, timeout
`default_nettype none
`timescale 1ns/1ps

module pkt_fifo_async_tb;
   import pkt_fifo_pkg::*;

   // tests take about 3000 clk_in cycles, most of it draining at the slower clock
   localparam int TIMEOUT_CYCLES = 20000;
   localparam int STREAM_PKTS    = 30;
   localparam int HELD_PKTS      = 10;
   localparam int MARGIN         = 8;     // words in flight across the sync

   logic              clk_in;
   logic              clk_out;
   logic              arst_n;
   logic              in_tvalid;
   logic [DATA_W-1:0] in_tdata;
   logic [KEEP_W-1:0] in_tkeep;
   logic              in_tlast;
   logic [CNT_W-1:0]  flow_ctl_thresh;
   logic              flow_ctl;
   logic [CNT_W-1:0]  drop_count;
   logic              out_tvalid;
   logic [DATA_W-1:0] out_tdata;
   logic [KEEP_W-1:0] out_tkeep;
   logic              out_tlast;
   logic              out_tready;

   integer            seed;
   logic [WORD_W-1:0] expq [$];           // {last, keep, data}
   logic [WORD_W-1:0] mon_word;
   int pushed = 0;
   int popped = 0;
   int errors = 0;
   int checks = 0;
   int cycles = 0;
   int drops_exp = 0;
   int ready_mode = 0;                    // 0 low, 1 high, 2 random
   int err_start;

   tb_clk_gen #(.PERIOD_NS(4)) clk_in_gen  (.clk(clk_in));
   tb_clk_gen #(.PERIOD_NS(6)) clk_out_gen (.clk(clk_out));

   pkt_fifo_async pkt_fifo_async_inst (
      .clk_in (clk_in), .clk_out (clk_out), .arst_n (arst_n),
      .in_tvalid (in_tvalid), .in_tdata (in_tdata), .in_tkeep (in_tkeep),
      .in_tlast (in_tlast), .flow_ctl_thresh (flow_ctl_thresh),
      .flow_ctl (flow_ctl), .drop_count (drop_count),
      .out_tvalid (out_tvalid), .out_tdata (out_tdata), .out_tkeep (out_tkeep),
      .out_tlast (out_tlast), .out_tready (out_tready)
   );

   // ---------------------------------------------------------------------
   // helpers
   // ---------------------------------------------------------------------
   function automatic int rand_range(input int lo, input int hi);
      int r;
      r = $random(seed) & 32'h7fffffff;
      return lo + (r % (hi - lo + 1));
   endfunction

   function automatic logic [WORD_W-1:0] random_word(input logic last);
      logic [DATA_W-1:0] data;
      logic [KEEP_W-1:0] keep;
      data = $random(seed);
      keep = KEEP_W'($random(seed));
      return {last, keep, data};
   endfunction

   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic drive_word(input logic valid, input logic [WORD_W-1:0] word);
      @(posedge clk_in);
      #1;
      in_tvalid = valid;
      {in_tlast, in_tkeep, in_tdata} = word;
   endtask

   task automatic idle(input int n);
      repeat (n) drive_word(1'b0, '0);
   endtask

   task automatic send_packet(input int len, input bit keep_it);
      logic [WORD_W-1:0] w;
      for (int i = 0; i < len; i++) begin
         w = random_word(i == len - 1);
         if (keep_it) begin
            expq.push_back(w);
            pushed++;
         end
         drive_word(1'b1, w);
      end
   endtask

   task automatic wait_for_room(input int len);
      while (pushed - popped + len > DEPTH - MARGIN) idle(1);
   endtask

   task automatic wait_drained();
      while (expq.size() != 0 || out_tvalid) idle(1);
      idle(20);
      @(negedge clk_out);
      compare_value("out_tvalid", 64'(out_tvalid), 64'(0));   // nothing left over
   endtask

   task automatic report_test(input string name, input int err_before);
      $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
   endtask

   // ---------------------------------------------------------------------
   // tests
   // ---------------------------------------------------------------------
   task automatic run_stream(input int npkts);
      int len;
      for (int p = 0; p < npkts; p++) begin
         len = rand_range(1, 12);
         wait_for_room(len);
         send_packet(len, 1'b1);
         idle(rand_range(0, 3));
      end
      wait_drained();
      compare_value("drop_count", 64'(drop_count), 64'(drops_exp));
   endtask

   task automatic run_overflow();
      int len;
      int accepted;
      int thresh;
      int err_flow;
      ready_mode = 0;
      idle(20);
      thresh = rand_range(0, DEPTH - 1);
      flow_ctl_thresh = CNT_W'(thresh);
      accepted = 0;
      for (int p = 0; p < HELD_PKTS; p++) begin
         len = rand_range(8, 24);
         // the output stage parks one word on top of the array
         if (len <= DEPTH + 1 - accepted) begin
            send_packet(len, 1'b1);
            accepted += len;
         end else begin
            send_packet(len, 1'b0);
            drops_exp++;
         end
         idle(rand_range(0, 2));
      end
      idle(4);
      compare_value("drop_count", 64'(drop_count), 64'(drops_exp));
      err_flow = errors;
      compare_value("flow_ctl", 64'(flow_ctl), 64'((accepted - 1) > thresh));
      report_test("flow control", err_flow);
      ready_mode = 1;
      wait_drained();
   endtask

   task automatic run_store_forward();
      logic [WORD_W-1:0] w;
      logic              seen;
      ready_mode = 1;
      for (int i = 0; i < 4; i++) begin
         w = random_word(i == 3);
         if (i == 3) begin
            idle(1);
            repeat (12) begin                 // tlast held back
               @(negedge clk_out);
               compare_value("out_tvalid", 64'(out_tvalid), 64'(0));
            end
         end
         expq.push_back(w);
         pushed++;
         drive_word(1'b1, w);
      end
      idle(1);                                 // tlast written here
      seen = 1'b0;
      repeat (10) begin
         @(negedge clk_out);
         if (out_tvalid) seen = 1'b1;
      end
      compare_value("out_tvalid after tlast", 64'(seen), 64'(1));
      wait_drained();
   endtask

   // ---------------------------------------------------------------------
   // output side
   // ---------------------------------------------------------------------
   initial begin
      out_tready = 1'b0;
      forever begin
         @(posedge clk_out);
         #1;
         case (ready_mode)
            0:       out_tready = 1'b0;
            1:       out_tready = 1'b1;
            default: out_tready = 1'($random(seed));
         endcase
      end
   end

   // transfer happens on the next rising edge
   always @(negedge clk_out) begin
      if (arst_n && out_tvalid && out_tready) begin
         if (expq.size() == 0) begin
            errors++;
            $display("Error at %0t ns: output word arrived with none expected", $time);
         end else begin
            mon_word = expq.pop_front();
            popped++;
            compare_value("out_tdata", 64'(out_tdata), 64'(mon_word[DATA_W-1:0]));
            compare_value("out_tkeep", 64'(out_tkeep), 64'(mon_word[DATA_W +: KEEP_W]));
            compare_value("out_tlast", 64'(out_tlast), 64'(mon_word[WORD_W-1]));
         end
      end
   end

   always @(posedge clk_in) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d clk_in cycles", TIMEOUT_CYCLES);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // ---------------------------------------------------------------------
   // main sequence
   // ---------------------------------------------------------------------
   initial begin
      seed = 32'hea30;
      arst_n = 1'b0;
      in_tvalid = 1'b0;
      in_tdata = '0;
      in_tkeep = '0;
      in_tlast = 1'b0;
      flow_ctl_thresh = CNT_W'(32);
      repeat (10) @(posedge clk_in);
      #1 arst_n = 1'b1;
      idle(5);                                 // reset release in both domains

      err_start = errors;
      compare_value("flow_ctl", 64'(flow_ctl), 64'(0));
      compare_value("drop_count", 64'(drop_count), 64'(0));
      @(negedge clk_out);
      compare_value("out_tvalid", 64'(out_tvalid), 64'(0));
      report_test("reset state", err_start);

      err_start = errors;
      ready_mode = 1;
      run_stream(STREAM_PKTS);
      report_test("streaming", err_start);

      err_start = errors;
      ready_mode = 2;
      run_stream(STREAM_PKTS);
      report_test("back-pressure", err_start);

      err_start = errors;
      run_overflow();
      report_test("overflow discard", err_start);

      err_start = errors;
      run_store_forward();
      report_test("store-and-forward", err_start);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
// free-running clock of a given period
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS = 4
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;   // 50% duty
   end

endmodule

`default_nettype wire
